/* files.f */
+incdir+source
source/core_pkg.sv
source/op_link_if.sv
source/isa_decoder.sv
source/issue_queue.sv
source/execute_unit.sv
source/core_top.sv
verif/core_props.sv
verif/core_tb.sv

/* Bender.yml */
package:
  name: core

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/core_pkg.sv
      - source/op_link_if.sv
      - source/isa_decoder.sv
      - source/issue_queue.sv
      - source/execute_unit.sv
      - source/core_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/core_props.sv
      - verif/core_tb.sv

/* verif/core_tb.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module core_tb;

  localparam int WAIT_LIMIT = 50;

  logic                       clk;
  logic                       rst;
  logic                       instr_valid;
  logic [`INST_WIDTH-1:0]     instr;
  logic                       instr_ready;
  logic                       exec_hold;
  logic                       wb_valid;
  logic [`REG_ADDR_WIDTH-1:0] wb_reg;
  logic [`DATA_WIDTH-1:0]     wb_data;

  string                      names[$];
  logic [`INST_WIDTH-1:0]     words[$];
  bit                         has_wb[$];
  logic [`REG_ADDR_WIDTH-1:0] exp_reg[$];
  logic [`DATA_WIDTH-1:0]     exp_data[$];

  // table indices of results still to come, in program order
  int exp_q[$];
  int seed = 13920;
  int checks = 0;
  int errors = 0;
  int timeouts = 0;
  int held = 0;
  int idx;

  core_top i_core_top (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_ready (instr_ready),
    .exec_hold   (exec_hold),
    .wb_valid    (wb_valid),
    .wb_reg      (wb_reg),
    .wb_data     (wb_data)
  );

  always #5 clk = ~clk;

  function automatic logic [`INST_WIDTH-1:0] reg_word(input logic [`OPCODE_WIDTH-1:0] opc,
                                                      input int rs, input int rt,
                                                      input int rd, input int shamt);
    core_pkg::instr_word_u w;
    w = '0;
    w.r.opcode = opc;
    w.r.rs = rs[`REG_ADDR_WIDTH-1:0];
    w.r.rt = rt[`REG_ADDR_WIDTH-1:0];
    w.r.rd = rd[`REG_ADDR_WIDTH-1:0];
    w.r.shamt = shamt[`SHAMT_WIDTH-1:0];
    return w;
  endfunction

  function automatic logic [`INST_WIDTH-1:0] imm_word(input logic [`OPCODE_WIDTH-1:0] opc,
                                                      input int rs, input int rt,
                                                      input logic [`IMM_WIDTH-1:0] imm);
    core_pkg::instr_word_u w;
    w = '0;
    w.i.opcode = opc;
    w.i.rs = rs[`REG_ADDR_WIDTH-1:0];
    w.i.rt = rt[`REG_ADDR_WIDTH-1:0];
    w.i.imm = imm;
    return w;
  endfunction

  task automatic add_entry(input string name, input logic [`INST_WIDTH-1:0] word,
                           input bit wb, input logic [`REG_ADDR_WIDTH-1:0] rd,
                           input logic [`DATA_WIDTH-1:0] data);
    names.push_back(name);
    words.push_back(word);
    has_wb.push_back(wb);
    exp_reg.push_back(rd);
    exp_data.push_back(data);
  endtask

  ////////////////////////////////////////
  // stimulus table, registers start at 0
  ////////////////////////////////////////

  task automatic build_table();
    add_entry("addi_r1", imm_word(`OPC_ADDI, 0, 1, 16'h0005), 1'b1, 5'd1, 32'h5);
    add_entry("add_fwd", reg_word(`OPC_ADD, 1, 1, 2, 0), 1'b1, 5'd2, 32'd10);
    add_entry("addi_zext", imm_word(`OPC_ADDI, 0, 3, 16'hffff), 1'b1, 5'd3, 32'h0000_ffff);
    add_entry("sub_wrap", reg_word(`OPC_SUB, 1, 2, 4, 0), 1'b1, 5'd4, 32'hffff_fffb);
    add_entry("add_wrap", reg_word(`OPC_ADD, 4, 2, 5, 0), 1'b1, 5'd5, 32'h0000_0005);
    add_entry("nop_zero", reg_word(6'd0, 1, 2, 6, 0), 1'b0, 5'd0, 32'h0);
    add_entry("andi", imm_word(`OPC_ANDI, 3, 6, 16'h0f0f), 1'b1, 5'd6, 32'h0000_0f0f);
    add_entry("ori_zext", imm_word(`OPC_ORI, 1, 7, 16'h8000), 1'b1, 5'd7, 32'h0000_8005);
    add_entry("and_rr", reg_word(`OPC_AND, 3, 4, 8, 0), 1'b1, 5'd8, 32'h0000_fffb);
    add_entry("or_rr", reg_word(`OPC_OR, 1, 2, 9, 0), 1'b1, 5'd9, 32'h0000_000f);
    add_entry("xor_rr", reg_word(`OPC_XOR, 3, 6, 10, 0), 1'b1, 5'd10, 32'h0000_f0f0);
    add_entry("sll", reg_word(`OPC_SLL, 1, 0, 11, 4), 1'b1, 5'd11, 32'h0000_0050);
    add_entry("unknown_op", reg_word(6'd63, 1, 1, 12, 0), 1'b0, 5'd0, 32'h0);
    add_entry("addi_r0", imm_word(`OPC_ADDI, 1, 0, 16'h0007), 1'b1, 5'd0, 32'h0000_000c);
    add_entry("add_r0", reg_word(`OPC_ADD, 0, 0, 12, 0), 1'b1, 5'd12, 32'h0);
    add_entry("addi_from_r0", imm_word(`OPC_ADDI, 0, 13, 16'h0001), 1'b1, 5'd13, 32'h1);
    add_entry("nop_tail", reg_word(6'd7, 2, 2, 14, 0), 1'b0, 5'd0, 32'h0);
  endtask

  task automatic apply_reset();
    rst <= 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    exp_q.delete();
  endtask

  // called at a rising edge, returns at the acceptance edge
  task automatic drive_word(input int n);
    int waited;
    waited = 0;
    instr_valid <= 1'b1;
    instr <= words[n];
    @(negedge clk);
    while (!instr_ready && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!instr_ready) begin
      timeouts++;
      $display("ERROR: instruction %s was never accepted", names[n]);
    end else if (has_wb[n]) begin
      exp_q.push_back(n);
    end
    @(posedge clk);
  endtask

  task automatic run_table(input int start, input bit gaps);
    int gap;
    for (int n = start; n < names.size(); n++) begin
      drive_word(n);
      if (gaps) begin
        gap = {$random(seed)} % 4;
        if (gap > 0) begin
          instr_valid <= 1'b0;
          repeat (gap) @(posedge clk);
        end
      end
    end
    instr_valid <= 1'b0;
  endtask

  // keep offering words under hold until ready stays low
  task automatic fill_under_hold(output int accepted);
    int low_cycles;
    accepted = 0;
    low_cycles = 0;
    exec_hold <= 1'b1;
    @(posedge clk);
    instr_valid <= 1'b1;
    instr <= words[0];
    while (low_cycles < 8 && accepted < names.size()) begin
      @(negedge clk);
      if (instr_ready) begin
        if (has_wb[accepted]) begin
          exp_q.push_back(accepted);
        end
        accepted++;
        low_cycles = 0;
      end else begin
        low_cycles++;
      end
      @(posedge clk);
      if (accepted < names.size()) begin
        instr <= words[accepted];
      end
    end
    instr_valid <= 1'b0;
    assert (accepted == `QUEUE_DEPTH + 1) else begin
      errors++;
      $display("FAILED hold_accept: expected %0d, actual %0d", `QUEUE_DEPTH + 1, accepted);
    end
  endtask

  task automatic drain_results();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      timeouts++;
      $display("ERROR: %0d expected write-backs never arrived", exp_q.size());
    end
    repeat (4) @(posedge clk);
  endtask

  ////////////////////////////////////////
  // write-back monitor
  ////////////////////////////////////////

  always @(negedge clk) begin
    if (!rst) begin
      if (exec_hold) begin
        assert (!wb_valid) else begin
          errors++;
          $display("ERROR: write-back appeared while exec_hold was high");
        end
      end
      if (wb_valid) begin
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("ERROR: write-back to r%0d when no result was expected", wb_reg);
        end
        if (exp_q.size() != 0) begin
          idx = exp_q.pop_front();
          checks++;
          assert (wb_reg == exp_reg[idx]) else begin
            errors++;
            $display("FAILED %s: expected r%0d, actual r%0d", names[idx], exp_reg[idx], wb_reg);
          end
          assert (wb_data == exp_data[idx]) else begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", names[idx], exp_data[idx], wb_data);
          end
        end
      end
    end
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    instr_valid = 1'b0;
    instr = '0;
    exec_hold = 1'b0;
    build_table();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    run_table(0, 1'b0);
    drain_results();
    // same table again with random gaps
    apply_reset();
    run_table(0, 1'b1);
    drain_results();
    apply_reset();
    fill_under_hold(held);
    exec_hold <= 1'b0;
    drain_results();
    run_table(held, 1'b0);
    drain_results();
    errors += i_core_top.i_issue_queue.i_core_props.violations;
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* verif/core_props.sv */
`timescale 1ns/1ps

module core_props #(
  parameter int DEPTH = 4
) (
  input logic                         clk,
  input logic                         rst,
  input logic [$clog2(DEPTH + 1)-1:0] count,
  input logic                         in_valid,
  input logic                         out_valid,
  input logic                         out_credit
);

  int violations = 0;
  // credits the queue holds for the single operand slot
  int qx_credits;

  always_ff @(posedge clk) begin
    if (rst) begin
      qx_credits <= 1;
    end else begin
      qx_credits <= qx_credits - int'(out_valid) + int'(out_credit);
    end
  end

  count_in_range: assert property (@(posedge clk) disable iff (rst) count <= DEPTH)
    else begin
      violations++;
      $error("issue queue count went above its depth");
    end

  // decoder credits must keep a full queue from being written
  no_write_when_full: assert property (@(posedge clk) disable iff (rst)
    in_valid |-> count < DEPTH)
    else begin
      violations++;
      $error("operation arrived while the issue queue was full");
    end

  // only a nonempty queue with a credit in hand may send
  send_needs_entry_and_credit: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> (count != 0 && (qx_credits > 0 || out_credit)))
    else begin
      violations++;
      $error("issue queue sent an operation while empty or without a credit");
    end

endmodule

bind issue_queue core_props #(
  .DEPTH (DEPTH)
) i_core_props (
  .clk        (clk),
  .rst        (rst),
  .count      (count),
  .in_valid   (in_link.valid),
  .out_valid  (out_link.valid),
  .out_credit (out_link.credit)
);

/* source/core_top.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module core_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       instr_valid,
  input  logic [`INST_WIDTH-1:0]     instr,
  output logic                       instr_ready,
  input  logic                       exec_hold,
  output logic                       wb_valid,
  output logic [`REG_ADDR_WIDTH-1:0] wb_reg,
  output logic [`DATA_WIDTH-1:0]     wb_data
);

  // decoder to queue, queue to execute
  op_link_if link_dq ();
  op_link_if link_qx ();

  isa_decoder #(
    .CREDITS (`QUEUE_DEPTH)
  ) i_isa_decoder (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_ready (instr_ready),
    .link        (link_dq.sender)
  );

  issue_queue #(
    .DEPTH (`QUEUE_DEPTH)
  ) i_issue_queue (
    .clk      (clk),
    .rst      (rst),
    .in_link  (link_dq.receiver),
    .out_link (link_qx.sender)
  );

  execute_unit i_execute_unit (
    .clk      (clk),
    .rst      (rst),
    .hold     (exec_hold),
    .link     (link_qx.receiver),
    .wb_valid (wb_valid),
    .wb_reg   (wb_reg),
    .wb_data  (wb_data)
  );

endmodule

/* source/execute_unit.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module execute_unit (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       hold,
  op_link_if.receiver                link,
  output logic                       wb_valid,
  output logic [`REG_ADDR_WIDTH-1:0] wb_reg,
  output logic [`DATA_WIDTH-1:0]     wb_data
);

  logic [`DATA_WIDTH-1:0]     regs [`NUM_REGS];

  logic                       op_valid;
  logic [`ALU_OP_WIDTH-1:0]   op_alu;
  logic [`REG_ADDR_WIDTH-1:0] op_rs;
  logic [`REG_ADDR_WIDTH-1:0] op_rt;
  logic [`REG_ADDR_WIDTH-1:0] op_dst;
  logic                       op_use_imm;
  logic [`IMM_WIDTH-1:0]      op_imm;
  logic [`SHAMT_WIDTH-1:0]    op_shamt;

  logic                       res_valid;
  logic [`REG_ADDR_WIDTH-1:0] res_dst;
  logic [`DATA_WIDTH-1:0]     res_data;

  logic                       advance;
  logic [`DATA_WIDTH-1:0]     a_val;
  logic [`DATA_WIDTH-1:0]     rt_val;
  logic [`DATA_WIDTH-1:0]     b_val;
  logic [`DATA_WIDTH-1:0]     alu_out;

  assign advance     = op_valid && !hold;
  assign link.credit = advance;

  ////////////////////////////////////////
  // operand stage
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      op_valid <= 1'b0;
    end else if (link.valid) begin
      op_valid <= 1'b1;
    end else if (advance) begin
      op_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (link.valid) begin
      op_alu     <= link.alu_op;
      op_rs      <= link.rs;
      op_rt      <= link.rt;
      op_dst     <= link.dst;
      op_use_imm <= link.use_imm;
      op_imm     <= link.imm;
      op_shamt   <= link.shamt;
    end
  end

  // bypass from the result register, r0 never forwarded
  assign a_val  = (res_valid && res_dst != '0 && res_dst == op_rs) ? res_data : regs[op_rs];
  assign rt_val = (res_valid && res_dst != '0 && res_dst == op_rt) ? res_data : regs[op_rt];
  assign b_val  = op_use_imm ? {{(`DATA_WIDTH - `IMM_WIDTH){1'b0}}, op_imm} : rt_val;

  always_comb begin
    case (op_alu)
      `ALU_ADD: alu_out = a_val + b_val;
      `ALU_SUB: alu_out = a_val - b_val;
      `ALU_AND: alu_out = a_val & b_val;
      `ALU_OR:  alu_out = a_val | b_val;
      `ALU_XOR: alu_out = a_val ^ b_val;
      `ALU_SLL: alu_out = a_val << op_shamt;
      default:  alu_out = '0;
    endcase
  end

  ////////////////////////////////////////
  // result register and write-back
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= advance;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      res_dst  <= op_dst;
      res_data <= alu_out;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (res_valid && res_dst != '0) begin
      regs[res_dst] <= res_data;
    end
  end

  assign wb_valid = res_valid;
  assign wb_reg   = res_dst;
  assign wb_data  = res_data;

endmodule

/* source/issue_queue.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module issue_queue #(
  parameter int DEPTH = `QUEUE_DEPTH
) (
  input  logic        clk,
  input  logic        rst,
  op_link_if.receiver in_link,
  op_link_if.sender   out_link
);

  localparam int ENTRY_W = `ALU_OP_WIDTH + 3 * `REG_ADDR_WIDTH + 1 + `IMM_WIDTH +
                           `SHAMT_WIDTH;
  localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W   = $clog2(DEPTH + 1);

  logic [ENTRY_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               exec_credit;
  logic               send;
  logic [ENTRY_W-1:0] head;

  // one slot downstream, credit may come back in the same cycle
  assign send = (count != '0) && (exec_credit || out_link.credit);
  assign head = mem[rd_ptr];

  assign out_link.valid = send;
  assign {out_link.alu_op, out_link.rs, out_link.rt, out_link.dst, out_link.use_imm,
          out_link.imm, out_link.shamt} = head;
  // freed slot goes straight back to the decoder
  assign in_link.credit = send;

  always_ff @(posedge clk) begin
    if (in_link.valid) begin
      mem[wr_ptr] <= {in_link.alu_op, in_link.rs, in_link.rt, in_link.dst, in_link.use_imm,
                      in_link.imm, in_link.shamt};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      exec_credit <= 1'b1;
    end else begin
      if (in_link.valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(in_link.valid) - CNT_W'(send);
      if (send && !out_link.credit) begin
        exec_credit <= 1'b0;
      end else if (out_link.credit && !send) begin
        exec_credit <= 1'b1;
      end
    end
  end

endmodule

/* source/isa_decoder.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module isa_decoder #(
  parameter int CREDITS = `QUEUE_DEPTH
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   instr_valid,
  input  logic [`INST_WIDTH-1:0] instr,
  output logic                   instr_ready,
  op_link_if.sender              link
);

  localparam int CNT_W = $clog2(CREDITS + 1);

  core_pkg::instr_word_u      word;
  logic                       is_op;
  logic [`ALU_OP_WIDTH-1:0]   alu_op;
  logic [`REG_ADDR_WIDTH-1:0] dst;
  logic                       use_imm;
  logic                       accept;
  logic                       take;
  logic [CNT_W-1:0]           credit_cnt;

  assign word = instr;

  ////////////////////////////////////////
  // opcode decode
  ////////////////////////////////////////

  always_comb begin
    is_op   = 1'b1;
    alu_op  = `ALU_ADD;
    dst     = word.r.rd;
    use_imm = 1'b0;
    case (word.r.opcode)
      `OPC_ADD: alu_op = `ALU_ADD;
      `OPC_SUB: alu_op = `ALU_SUB;
      `OPC_AND: alu_op = `ALU_AND;
      `OPC_OR:  alu_op = `ALU_OR;
      `OPC_XOR: alu_op = `ALU_XOR;
      `OPC_SLL: alu_op = `ALU_SLL;
      `OPC_ADDI, `OPC_ANDI, `OPC_ORI: begin
        // immediate format writes rt
        dst     = word.i.rt;
        use_imm = 1'b1;
        if (word.i.opcode == `OPC_ANDI) begin
          alu_op = `ALU_AND;
        end else if (word.i.opcode == `OPC_ORI) begin
          alu_op = `ALU_OR;
        end
      end
      default: is_op = 1'b0;
    endcase
  end

  assign instr_ready = (credit_cnt != '0);
  assign accept      = instr_valid && instr_ready;
  // nops are swallowed here
  assign take        = accept && is_op;

  always_ff @(posedge clk) begin
    if (rst) begin
      link.valid <= 1'b0;
      credit_cnt <= CNT_W'(CREDITS);
    end else begin
      link.valid <= take;
      credit_cnt <= credit_cnt - CNT_W'(take) + CNT_W'(link.credit);
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      link.alu_op  <= alu_op;
      link.rs      <= word.r.rs;
      link.rt      <= word.r.rt;
      link.dst     <= dst;
      link.use_imm <= use_imm;
      link.imm     <= word.i.imm;
      link.shamt   <= word.r.shamt;
    end
  end

endmodule

/* source/op_link_if.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

interface op_link_if;
  logic                       valid;
  logic [`ALU_OP_WIDTH-1:0]   alu_op;
  logic [`REG_ADDR_WIDTH-1:0] rs;
  logic [`REG_ADDR_WIDTH-1:0] rt;
  logic [`REG_ADDR_WIDTH-1:0] dst;
  logic                       use_imm;
  logic [`IMM_WIDTH-1:0]      imm;
  logic [`SHAMT_WIDTH-1:0]    shamt;
  // slot freed at the receiver
  logic                       credit;

  modport sender (
    output valid, alu_op, rs, rt, dst, use_imm, imm, shamt,
    input  credit
  );
  modport receiver (
    input  valid, alu_op, rs, rt, dst, use_imm, imm, shamt,
    output credit
  );
endinterface

/* source/core_pkg.sv */
package core_pkg;

`include "core_cfg.svh"

  // one instruction word, two field layouts
  typedef union packed {
    struct packed {
      logic [`OPCODE_WIDTH-1:0]   opcode;
      logic [`REG_ADDR_WIDTH-1:0] rs;
      logic [`REG_ADDR_WIDTH-1:0] rt;
      logic [`REG_ADDR_WIDTH-1:0] rd;
      logic [`SHAMT_WIDTH-1:0]    shamt;
      logic [5:0]                 spare;
    } r;
    struct packed {
      logic [`OPCODE_WIDTH-1:0]   opcode;
      logic [`REG_ADDR_WIDTH-1:0] rs;
      logic [`REG_ADDR_WIDTH-1:0] rt;
      logic [`IMM_WIDTH-1:0]      imm;
    } i;
  } instr_word_u;

endpackage

/* source/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

`define DATA_WIDTH      32
`define INST_WIDTH      32
`define REG_ADDR_WIDTH  5
`define NUM_REGS        32
`define OPCODE_WIDTH    6
`define IMM_WIDTH       16
`define SHAMT_WIDTH     5
`define ALU_OP_WIDTH    3
`define QUEUE_DEPTH     4

// register format
`define OPC_ADD   6'd1
`define OPC_SUB   6'd2
`define OPC_AND   6'd3
`define OPC_OR    6'd4
`define OPC_XOR   6'd5
`define OPC_SLL   6'd6
// immediate format
`define OPC_ADDI  6'd9
`define OPC_ANDI  6'd11
`define OPC_ORI   6'd12

`define ALU_ADD   3'd0
`define ALU_SUB   3'd1
`define ALU_AND   3'd2
`define ALU_OR    3'd3
`define ALU_XOR   3'd4
`define ALU_SLL   3'd5

`endif
